// File: filelist.f
+incdir+logic
logic/rvIsaPkg.sv
logic/rvCtrlPkg.sv
logic/decodeIf.sv
logic/immGen.sv
logic/uCodeCtrl.sv
logic/regFile.sv
logic/decodeStage.sv
logic/rvDecodeTop.sv
bench/tbClock.sv
bench/rvDecodeTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module rvDecodeTb \
    -f filelist.f -Mdir obj_dir -o rvDecodeSim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/rvDecodeSim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: bench/rvDecodeTb.sv
`timescale 1ns/10ps

module rvDecodeTb import rvIsaPkg::*, rvCtrlPkg::*; ();

    localparam int numInstr      = 3000;
    localparam int sweepLen      = 32;   // one read of every register after reset
    localparam int timeoutCycles = 4000 + numInstr * 8;

    typedef struct packed {
        logic [15:0]     ctrl;
        logic [xlen-1:0] imm;
        logic            illegal;
    } modelOutT;

    logic                clk;
    logic                arstN;
    logic [xlen-1:0]     instr;
    logic                instrValid;
    logic                stall;
    logic                wrEn;
    logic [regAddrW-1:0] wrAddr;
    logic [xlen-1:0]     wrData;
    logic                outValid;
    ctrlWordT            ctrl;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [regAddrW-1:0] rd;
    logic                illegal;

    integer seed     = 70105;
    int     errors   = 0;
    int     checks   = 0;
    int     accepted = 0;
    int     cycles   = 0;

    // model state
    logic [xlen-1:0]     shadow [32];
    logic                expValid;
    logic [15:0]         expCtrl;
    logic                expIllegal;
    logic [xlen-1:0]     expImm;
    logic [xlen-1:0]     expRs1;
    logic [xlen-1:0]     expRs2;
    logic [regAddrW-1:0] expRd;
    logic                hasData;   // a word was captured since reset

    tbClock tbClock_i (
        .clk   (clk),
        .arstN (arstN)
    );

    rvDecodeTop #(
        .NumRegs (32)
    ) rvDecodeTop_i (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .outValid   (outValid),
        .ctrl       (ctrl),
        .imm        (imm),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .rd         (rd),
        .illegal    (illegal)
    );

    // ##########################################################
    // decode model
    function automatic aluOpT baseAlu(logic [2:0] f3);
        case (f3)
            3'd0:    return aluAdd;
            3'd1:    return aluSll;
            3'd2:    return aluSlt;
            3'd3:    return aluSltu;
            3'd4:    return aluXor;
            3'd5:    return aluSrl;
            3'd6:    return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic modelOutT modelDecode(logic [xlen-1:0] w);
        modelOutT   m;
        logic [2:0] f3;
        logic [6:0] f7;
        aluOpT      alu;
        srcAT       srcA;
        srcBT       srcB;
        logic [2:0] ldExt;
        logic [5:0] flags;   // memRead memWrite regWrite memToReg branch jump
        logic       live;    // has a control word
        logic       nop;     // legal with a zero word
        f3    = w[14:12];
        f7    = w[31:25];
        alu   = aluAdd;
        srcA  = srcARs1;
        srcB  = srcBImm;
        ldExt = 3'd0;
        flags = 6'b001000;
        live  = 1'b0;
        nop   = 1'b0;
        m.imm = '0;
        case (w[6:0])
            7'b0110111: begin   // lui
                m.imm = {w[31:12], 12'd0};
                alu   = aluPassB;
                srcA  = srcAZero;
                live  = 1'b1;
            end
            7'b0010111: begin   // auipc
                m.imm = {w[31:12], 12'd0};
                srcA  = srcAPc;
                live  = 1'b1;
            end
            7'b1101111: begin   // jal
                m.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                srcA  = srcAPc;
                flags = 6'b001001;
                live  = 1'b1;
            end
            7'b1100111: begin   // jalr
                m.imm = {{20{w[31]}}, w[31:20]};
                flags = 6'b001001;
                live  = (f3 == 3'd0);
            end
            7'b1100011: begin
                m.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                alu   = f3[2] ? (f3[1] ? aluSltu : aluSlt) : aluSub;
                srcB  = srcBRs2;
                flags = 6'b000010;
                live  = (f3 != 3'd2) && (f3 != 3'd3);
            end
            7'b0000011: begin
                m.imm = {{20{w[31]}}, w[31:20]};
                ldExt = f3;
                flags = 6'b101100;
                live  = (f3 != 3'd3) && (f3 < 3'd6);
            end
            7'b0100011: begin
                m.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                ldExt = f3;
                flags = 6'b010000;
                live  = (f3 < 3'd3);
            end
            7'b0010011: begin
                alu = (f7 == 7'h20 && f3 == 3'd5) ? aluSra : baseAlu(f3);
                if (f3[1:0] == 2'b01) begin   // shifts take a zero-extended shamt
                    m.imm = {27'd0, w[24:20]};
                    live  = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);
                end else begin
                    m.imm = {{20{w[31]}}, w[31:20]};
                    live  = 1'b1;
                end
            end
            7'b0110011: begin
                alu  = (f7 == 7'h20) ? ((f3 == 3'd0) ? aluSub : aluSra) : baseAlu(f3);
                srcB = srcBRs2;
                live = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            7'b0001111: nop = (f3 == 3'd0);
            7'b1110011: nop = (w[31:21] == 11'd0) && (w[19:7] == 13'd0);
            default:    nop = 1'b0;
        endcase
        m.ctrl    = live ? {alu, srcA, srcB, ldExt, flags} : 16'd0;
        m.illegal = !(live || nop);
        return m;
    endfunction

    // ##########################################################
    // stimulus
    function automatic logic [xlen-1:0] randomInstr();
        logic [xlen-1:0] w;
        int              kind;
        int              k;
        w    = $random(seed);
        kind = {$random(seed)} % 100;
        k    = {$random(seed)} % 6;
        if (kind < 10) begin
            return w;   // raw word
        end
        case (kind % 10)
            0: begin
                w[6:0]   = opR;
                w[31:25] = (w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = opImm;
                if (w[13:12] == 2'b01) begin
                    w[31:25] = (w[30] && w[14]) ? 7'h20 : 7'h00;
                end
            end
            2: begin
                w[6:0]   = opLoad;
                w[14:12] = (k % 5 < 3) ? 3'(k % 5) : 3'(k % 5 + 1);
            end
            3: begin
                w[6:0]   = opStore;
                w[14:12] = 3'(k % 3);
            end
            4: begin
                w[6:0]   = opBranch;
                w[14:12] = (k < 2) ? 3'(k) : 3'(k + 2);
            end
            5: w[6:0] = opJal;
            6: begin
                w[6:0]   = opJalr;
                w[14:12] = 3'd0;
            end
            7: w[6:0] = opLui;
            8: w[6:0] = opAuipc;
            default: begin
                if (k < 3) begin
                    w[6:0]   = opFence;
                    w[14:12] = 3'd0;
                end else begin
                    w = {11'd0, w[20], 13'd0, opSystem};   // ecall or ebreak
                end
            end
        endcase
        return w;
    endfunction

    task automatic driveNext();
        logic [xlen-1:0] r;
        if (accepted < sweepLen) begin
            instr      = {7'd0, 5'(31 - accepted), 5'(accepted), 3'd0, 5'(accepted), opR};
            instrValid = 1'b1;
            stall      = 1'b0;
            wrEn       = 1'b0;
        end else begin
            if (!stall) begin   // a stalled word is held upstream
                instr      = randomInstr();
                instrValid = ({$random(seed)} % 4) != 0;
            end
            stall  = ({$random(seed)} % 5) == 0;
            r      = $random(seed);
            wrEn   = r[0];
            wrAddr = r[5:1];
            wrData = $random(seed);
        end
    endtask

    // ##########################################################
    // model step and checks
    function automatic logic [xlen-1:0] readShadow(logic [regAddrW-1:0] a);
        if (a == '0) begin
            return '0;
        end
        if (wrEn && wrAddr == a) begin
            return wrData;   // same-cycle write
        end
        return shadow[a];
    endfunction

    task automatic stepModel();
        modelOutT d;
        if (!stall) begin
            expValid = instrValid;
            if (instrValid) begin
                d          = modelDecode(instr);
                expCtrl    = d.ctrl;
                expImm     = d.imm;
                expIllegal = d.illegal;
                expRd      = instr[11:7];
                expRs1     = readShadow(instr[19:15]);
                expRs2     = readShadow(instr[24:20]);
                hasData    = 1'b1;
                accepted++;
            end
        end
        if (wrEn && wrAddr != '0) begin
            shadow[wrAddr] = wrData;
        end
    endtask

    task automatic checkValue(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareOutputs();
        checkValue("outValid", 32'(outValid), 32'(expValid));
        checkValue("ctrl", 32'(ctrl), 32'(expCtrl));
        checkValue("illegal", 32'(illegal), 32'(expIllegal));
        if (hasData) begin
            checkValue("imm", imm, expImm);
            checkValue("rs1Data", rs1Data, expRs1);
            checkValue("rs2Data", rs2Data, expRs2);
            checkValue("rd", 32'(rd), 32'(expRd));
        end
    endtask

    initial begin
        instr      = '0;
        instrValid = 1'b0;
        stall      = 1'b0;
        wrEn       = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        expValid   = 1'b0;
        expCtrl    = '0;
        expIllegal = 1'b0;
        hasData    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        compareOutputs();   // still in reset
        wait (arstN === 1'b1);
        driveNext();
        while (accepted < sweepLen + numInstr) begin
            @(posedge clk);
            stepModel();
            #1;
            compareOutputs();
            driveNext();
        end
        $display("rvDecodeTb: %0d instructions, %0d checks, %0d errors", accepted, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not complete within %0d cycles", timeoutCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: bench/tbClock.sv
`timescale 1ns/10ps

module tbClock #(
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // release just after an edge
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule

// File: logic/rvDecodeTop.sv
`timescale 1ns/10ps

module rvDecodeTop import rvIsaPkg::*, rvCtrlPkg::*; #(
    parameter int NumRegs = 32   // 16 for rv32e
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic [xlen-1:0]     instr,
    input  logic                instrValid,
    input  logic                stall,
    input  logic                wrEn,      // writeback from a later stage
    input  logic [regAddrW-1:0] wrAddr,
    input  logic [xlen-1:0]     wrData,
    output logic                outValid,
    output ctrlWordT            ctrl,
    output logic [xlen-1:0]     imm,
    output logic [xlen-1:0]     rs1Data,
    output logic [xlen-1:0]     rs2Data,
    output logic [regAddrW-1:0] rd,
    output logic                illegal
);

    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [xlen-1:0]     rfRs1Data;
    logic [xlen-1:0]     rfRs2Data;

    regFile #(
        .NumRegs (NumRegs)
    ) regFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rfRs1Data),
        .rs2Data (rfRs2Data),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    decodeStage #(
        .NumRegs (NumRegs)
    ) decodeStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rfRs1Data),
        .rs2Data    (rfRs2Data),
        .outValid   (outValid),
        .ctrl       (ctrl),
        .imm        (imm),
        .outRs1Data (rs1Data),
        .outRs2Data (rs2Data),
        .rd         (rd),
        .illegal    (illegal)
    );

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import rvIsaPkg::*, rvCtrlPkg::*; #(
    parameter int NumRegs = 32
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic [xlen-1:0]     instr,
    input  logic                instrValid,
    input  logic                stall,
    output logic [regAddrW-1:0] rs1Addr,
    output logic [regAddrW-1:0] rs2Addr,
    input  logic [xlen-1:0]     rs1Data,
    input  logic [xlen-1:0]     rs2Data,
    output logic                outValid,
    output ctrlWordT            ctrl,
    output logic [xlen-1:0]     imm,
    output logic [xlen-1:0]     outRs1Data,
    output logic [xlen-1:0]     outRs2Data,
    output logic [regAddrW-1:0] rd,
    output logic                illegal
);

    opcodeT          opcode;
    ctrlWordT        ucCtrl;
    logic [xlen-1:0] immVal;
    logic            ucIllegal;
    logic            badIndex;   // register field past NumRegs (rv32e)

    decodeIf dIf ();

    immGen immGen_i (
        .instr (instr),
        .imm   (immVal)
    );

    uCodeCtrl uCodeCtrl_i (
        .instr   (instr),
        .ctrl    (ucCtrl),
        .illegal (ucIllegal)
    );

    assign opcode  = getOpcode(instr);
    assign rs1Addr = getRs1(instr);
    assign rs2Addr = getRs2(instr);

    assign badIndex = (usesRs1(opcode) && int'(rs1Addr) >= NumRegs) ||
                      (usesRs2(opcode) && int'(rs2Addr) >= NumRegs) ||
                      (usesRd(opcode) && int'(getRd(instr)) >= NumRegs);

    // ##########################################################
    // decode side
    assign dIf.ctrl    = ucCtrl;
    assign dIf.imm     = immVal;
    assign dIf.rs1Data = rs1Data;
    assign dIf.rs2Data = rs2Data;
    assign dIf.rd      = getRd(instr);
    assign dIf.illegal = ucIllegal | badIndex;
    assign dIf.valid   = instrValid;

    // ##########################################################
    // output register frozen while stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            ctrl     <= '0;
            illegal  <= 1'b0;
        end else if (!stall) begin
            outValid <= dIf.valid;
            if (dIf.valid) begin
                ctrl    <= dIf.ctrl;
                illegal <= dIf.illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && dIf.valid) begin
            imm        <= dIf.imm;
            outRs1Data <= dIf.rs1Data;
            outRs2Data <= dIf.rs2Data;
            rd         <= dIf.rd;
        end
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/10ps

module regFile import rvIsaPkg::*; #(
    parameter int NumRegs = 32
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rs1Addr,
    input  logic [regAddrW-1:0] rs2Addr,
    output logic [xlen-1:0]     rs1Data,
    output logic [xlen-1:0]     rs2Data,
    input  logic                wrEn,
    input  logic [regAddrW-1:0] wrAddr,
    input  logic [xlen-1:0]     wrData
);

    localparam int idxW = $clog2(NumRegs);

    logic [xlen-1:0] regs [NumRegs];
    logic            wrHit;   // write to a real register other than x0

    assign wrHit = wrEn && wrAddr != '0 && int'(wrAddr) < NumRegs;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrHit) begin
            regs[wrAddr[idxW-1:0]] <= wrData;
        end
    end

    function automatic logic [xlen-1:0] readPort(logic [regAddrW-1:0] addr);
        if (addr == '0 || int'(addr) >= NumRegs) begin
            return '0;
        end
        if (wrHit && addr == wrAddr) begin
            return wrData;  // write-through
        end
        return regs[addr[idxW-1:0]];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr);
    end

    always_comb begin
        rs2Data = readPort(rs2Addr);
    end

endmodule

// File: logic/uCodeCtrl.sv
`timescale 1ns/10ps

module uCodeCtrl import rvIsaPkg::*, rvCtrlPkg::*; (
    input  logic [xlen-1:0] instr,
    output ctrlWordT        ctrl,
    output logic            illegal
);

    typedef enum logic [1:0] {
        keyOp,       // lui, auipc, jal
        keyF3Op,
        keyF7F3Op    // r-type and shift-immediates
    } keyFormT;

    opcodeT               opcode;
    logic [funct3W-1:0]   funct3;
    logic [funct7W-1:0]   funct7;
    logic                 isShiftImm;
    keyFormT              keyForm;
    logic [ucodeKeyW-1:0] key;
    logic                 hit;
    logic                 isNop;

    assign opcode     = getOpcode(instr);
    assign funct3     = getFunct3(instr);
    assign funct7     = getFunct7(instr);
    assign isShiftImm = ~funct3[1] & funct3[0];

    // ##########################################################
    // key formation
    always_comb begin
        case (opcode)
            opR:                  keyForm = keyF7F3Op;
            opImm:                keyForm = isShiftImm ? keyF7F3Op : keyF3Op;
            opJalr, opLoad, opStore, opBranch,
            opFence, opSystem:    keyForm = keyF3Op;
            opLui, opAuipc, opJal: keyForm = keyOp;
            default:              keyForm = keyF7F3Op;
        endcase
    end

    always_comb begin
        case (keyForm)
            keyOp:   key = {{funct7W{1'b0}}, {funct3W{1'b0}}, opcode};
            keyF3Op: key = {{funct7W{1'b0}}, funct3, opcode};
            default: key = {funct7, funct3, opcode};
        endcase
    end

    // ##########################################################
    // table lookup
    always_comb begin
        ctrl = '0;
        hit  = 1'b0;
        for (int i = 0; i < ucodeCount; i++) begin
            if (ucodeTable[i].key == key) begin
                ctrl = ucodeTable[i].ctrl;
                hit  = 1'b1;
            end
        end
    end

    // fence and bare ecall or ebreak give a zero word
    assign isNop = (opcode == opFence && funct3 == 3'd0) ||
                   (opcode == opSystem && instr[31:21] == '0 && instr[19:7] == '0);

    assign illegal = ~hit & ~isNop;

endmodule

// File: logic/immGen.sv
`timescale 1ns/10ps

module immGen import rvIsaPkg::*; (
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] imm
);

    logic [funct3W-1:0] funct3;
    logic               isShiftImm;   // slli, srli, srai

    assign funct3     = getFunct3(instr);
    assign isShiftImm = ~funct3[1] & funct3[0];

    always_comb begin
        case (getOpcode(instr))
            opLoad, opJalr: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            opImm: begin
                if (isShiftImm) begin
                    imm = {27'd0, instr[24:20]};  // shamt
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
            opStore:        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch:       imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            opLui, opAuipc: imm = {instr[31:12], 12'd0};
            opJal:          imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

endmodule

// File: logic/decodeIf.sv
`timescale 1ns/10ps

interface decodeIf import rvIsaPkg::*, rvCtrlPkg::*; ();

    ctrlWordT            ctrl;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [regAddrW-1:0] rd;
    logic                illegal;
    logic                valid;

    // decode logic side
    modport src (
        output ctrl, imm, rs1Data, rs2Data, rd, illegal, valid
    );

    // output register side
    modport dst (
        input ctrl, imm, rs1Data, rs2Data, rd, illegal, valid
    );

endinterface

// File: logic/rvCtrlPkg.sv
package rvCtrlPkg;
    import rvIsaPkg::*;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10   // lui
    } aluOpT;

    typedef enum logic [1:0] {
        srcARs1  = 2'd0,
        srcAPc   = 2'd1,
        srcAZero = 2'd2
    } srcAT;

    typedef enum logic {
        srcBRs2 = 1'b0,
        srcBImm = 1'b1
    } srcBT;

    // 16 bits with aluOp in the msbs
    typedef struct packed {
        aluOpT      aluOp;
        srcAT       srcA;
        srcBT       srcB;
        logic [2:0] ldExt;     // funct3 of loads and stores
        logic       memRead;
        logic       memWrite;
        logic       regWrite;
        logic       memToReg;
        logic       branch;
        logic       jump;
    } ctrlWordT;

    typedef struct packed {
        logic [ucodeKeyW-1:0] key;
        ctrlWordT             ctrl;
    } ucodeEntryT;

    localparam int ucodeCount = 37;

    typedef ucodeEntryT [ucodeCount-1:0] ucodeTableT;

    // ##########################################################
    // microcode table
    // each UCODE line fills the next slot in header order
`define UCODE(F7, F3, OP, ALU, SA, SB, LDX, FLAGS) \
        tbl[idx] = '{key: {F7, F3, OP}, ctrl: {ALU, SA, SB, LDX, FLAGS}}; \
        idx = idx + 1;

    function automatic ucodeTableT buildTable();
        ucodeTableT tbl;
        int         idx;
        tbl = '0;
        idx = 0;
`include "ucode.svh"
        return tbl;
    endfunction

`undef UCODE

    localparam ucodeTableT ucodeTable = buildTable();

endpackage

// File: logic/rvIsaPkg.sv
package rvIsaPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // ##########################################################
    // instruction field layout
    localparam int opcodeW   = 7;
    localparam int funct3W   = 3;
    localparam int funct7W   = 7;
    localparam int rdLsb     = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb    = 15;
    localparam int rs2Lsb    = 20;
    localparam int funct7Lsb = 25;

    localparam int ucodeKeyW = funct7W + funct3W + opcodeW;  // {funct7, funct3, opcode}

    typedef enum logic [opcodeW-1:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opFence  = 7'b0001111,
        opSystem = 7'b1110011
    } opcodeT;

    // ##########################################################
    // field extraction
    function automatic opcodeT getOpcode(logic [xlen-1:0] instr);
        return opcodeT'(instr[opcodeW-1:0]);
    endfunction

    function automatic logic [regAddrW-1:0] getRd(logic [xlen-1:0] instr);
        return instr[rdLsb +: regAddrW];
    endfunction

    function automatic logic [regAddrW-1:0] getRs1(logic [xlen-1:0] instr);
        return instr[rs1Lsb +: regAddrW];
    endfunction

    function automatic logic [regAddrW-1:0] getRs2(logic [xlen-1:0] instr);
        return instr[rs2Lsb +: regAddrW];
    endfunction

    function automatic logic [funct3W-1:0] getFunct3(logic [xlen-1:0] instr);
        return instr[funct3Lsb +: funct3W];
    endfunction

    function automatic logic [funct7W-1:0] getFunct7(logic [xlen-1:0] instr);
        return instr[funct7Lsb +: funct7W];
    endfunction

    // which register fields a format really uses
    function automatic logic usesRs1(opcodeT op);
        return op inside {opR, opImm, opLoad, opStore, opBranch, opJalr};
    endfunction

    function automatic logic usesRs2(opcodeT op);
        return op inside {opR, opStore, opBranch};
    endfunction

    function automatic logic usesRd(opcodeT op);
        return op inside {opR, opImm, opLoad, opJal, opJalr, opLui, opAuipc};
    endfunction

endpackage

// File: logic/ucode.svh
`ifndef UCODE_SVH
`define UCODE_SVH

// UCODE(funct7, funct3, opcode, aluOp, srcA, srcB, ldExt, flags)
// flags are {memRead, memWrite, regWrite, memToReg, branch, jump}
// key fields outside the format stay zero

// ##########################################################
// opcode only
`UCODE(7'h00, 3'd0, opLui,    aluPassB, srcAZero, srcBImm, 3'd0, 6'b001000) // lui
`UCODE(7'h00, 3'd0, opAuipc,  aluAdd,   srcAPc,   srcBImm, 3'd0, 6'b001000) // auipc
`UCODE(7'h00, 3'd0, opJal,    aluAdd,   srcAPc,   srcBImm, 3'd0, 6'b001001) // jal

// ##########################################################
// funct3 + opcode
`UCODE(7'h00, 3'd0, opJalr,   aluAdd,   srcARs1,  srcBImm, 3'd0, 6'b001001) // jalr

// branch compare runs in the alu
`UCODE(7'h00, 3'd0, opBranch, aluSub,   srcARs1,  srcBRs2, 3'd0, 6'b000010) // beq
`UCODE(7'h00, 3'd1, opBranch, aluSub,   srcARs1,  srcBRs2, 3'd0, 6'b000010) // bne
`UCODE(7'h00, 3'd4, opBranch, aluSlt,   srcARs1,  srcBRs2, 3'd0, 6'b000010) // blt
`UCODE(7'h00, 3'd5, opBranch, aluSlt,   srcARs1,  srcBRs2, 3'd0, 6'b000010) // bge
`UCODE(7'h00, 3'd6, opBranch, aluSltu,  srcARs1,  srcBRs2, 3'd0, 6'b000010) // bltu
`UCODE(7'h00, 3'd7, opBranch, aluSltu,  srcARs1,  srcBRs2, 3'd0, 6'b000010) // bgeu

`UCODE(7'h00, 3'd0, opLoad,   aluAdd,   srcARs1,  srcBImm, 3'd0, 6'b101100) // lb
`UCODE(7'h00, 3'd1, opLoad,   aluAdd,   srcARs1,  srcBImm, 3'd1, 6'b101100) // lh
`UCODE(7'h00, 3'd2, opLoad,   aluAdd,   srcARs1,  srcBImm, 3'd2, 6'b101100) // lw
`UCODE(7'h00, 3'd4, opLoad,   aluAdd,   srcARs1,  srcBImm, 3'd4, 6'b101100) // lbu
`UCODE(7'h00, 3'd5, opLoad,   aluAdd,   srcARs1,  srcBImm, 3'd5, 6'b101100) // lhu

`UCODE(7'h00, 3'd0, opStore,  aluAdd,   srcARs1,  srcBImm, 3'd0, 6'b010000) // sb
`UCODE(7'h00, 3'd1, opStore,  aluAdd,   srcARs1,  srcBImm, 3'd1, 6'b010000) // sh
`UCODE(7'h00, 3'd2, opStore,  aluAdd,   srcARs1,  srcBImm, 3'd2, 6'b010000) // sw

`UCODE(7'h00, 3'd0, opImm,    aluAdd,   srcARs1,  srcBImm, 3'd0, 6'b001000) // addi
`UCODE(7'h00, 3'd2, opImm,    aluSlt,   srcARs1,  srcBImm, 3'd0, 6'b001000) // slti
`UCODE(7'h00, 3'd3, opImm,    aluSltu,  srcARs1,  srcBImm, 3'd0, 6'b001000) // sltiu
`UCODE(7'h00, 3'd4, opImm,    aluXor,   srcARs1,  srcBImm, 3'd0, 6'b001000) // xori
`UCODE(7'h00, 3'd6, opImm,    aluOr,    srcARs1,  srcBImm, 3'd0, 6'b001000) // ori
`UCODE(7'h00, 3'd7, opImm,    aluAnd,   srcARs1,  srcBImm, 3'd0, 6'b001000) // andi

// ##########################################################
// funct7 + funct3 + opcode
`UCODE(7'h00, 3'd1, opImm,    aluSll,   srcARs1,  srcBImm, 3'd0, 6'b001000) // slli
`UCODE(7'h00, 3'd5, opImm,    aluSrl,   srcARs1,  srcBImm, 3'd0, 6'b001000) // srli
`UCODE(7'h20, 3'd5, opImm,    aluSra,   srcARs1,  srcBImm, 3'd0, 6'b001000) // srai

`UCODE(7'h00, 3'd0, opR,      aluAdd,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // add
`UCODE(7'h20, 3'd0, opR,      aluSub,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // sub
`UCODE(7'h00, 3'd1, opR,      aluSll,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // sll
`UCODE(7'h00, 3'd2, opR,      aluSlt,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // slt
`UCODE(7'h00, 3'd3, opR,      aluSltu,  srcARs1,  srcBRs2, 3'd0, 6'b001000) // sltu
`UCODE(7'h00, 3'd4, opR,      aluXor,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // xor
`UCODE(7'h00, 3'd5, opR,      aluSrl,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // srl
`UCODE(7'h20, 3'd5, opR,      aluSra,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // sra
`UCODE(7'h00, 3'd6, opR,      aluOr,    srcARs1,  srcBRs2, 3'd0, 6'b001000) // or
`UCODE(7'h00, 3'd7, opR,      aluAnd,   srcARs1,  srcBRs2, 3'd0, 6'b001000) // and

`endif
